//--- common/cpu_consts.svh
/*
 * Widths and sizes of the pipelined RV32I subset core.
 * Included by the package and by blocks that size arrays or indices.
 */
`ifndef CPU_CONSTS_SVH
`define CPU_CONSTS_SVH

`define CPU_XLEN      32    // Data and address width
`define CPU_MEM_WORDS 256   // Unified memory depth, 1 KiB
`define CPU_MEM_AW    8     // Word index, byte address bits 9:2
`define CPU_NUM_REGS  32    // Architectural registers x0..x31

`endif

//--- common/cpu_pkg.sv
/*
 * Shared types of the core: operation codes, control bits and the
 * payloads carried by the four stage registers.
 */
`default_nettype none

`include "cpu_consts.svh"

package cpu_pkg;

    typedef logic [`CPU_XLEN-1:0]             word_t;     // Data, address or instruction
    typedef logic [$clog2(`CPU_NUM_REGS)-1:0] reg_idx_t;  // Register number

    // Operation selected for execute
    typedef enum logic [2:0] {
        OP_ADD   = 3'd0,    // ADD and ADDI
        OP_SUB   = 3'd1,
        OP_AND   = 3'd2,
        OP_OR    = 3'd3,
        OP_XOR   = 3'd4,
        OP_LOAD  = 3'd5,    // LW, address is rs1 + imm
        OP_STORE = 3'd6     // SW, address is rs1 + imm
    } op_e;

    typedef struct packed {
        op_e  op;
        logic use_imm;      // Operand B taken from the immediate
        logic reg_write;    // Result goes to rd
        logic mem_read;
        logic mem_write;
    } ctrl_t;

    // Fetch to decode
    typedef struct packed {
        logic  valid;
        word_t pc;
        word_t instr;
    } if_id_t;

    // Decode to execute
    typedef struct packed {
        logic     valid;
        ctrl_t    ctrl;
        word_t    pc;
        word_t    rs1_data;
        word_t    rs2_data;
        word_t    imm;
        reg_idx_t rd;
    } id_ex_t;

    // Execute to memory
    typedef struct packed {
        logic     valid;
        ctrl_t    ctrl;
        reg_idx_t rd;
        word_t    result;       // ALU value or effective address
        word_t    store_data;
    } ex_mem_t;

    // Memory to write-back
    typedef struct packed {
        logic     valid;
        logic     reg_write;
        reg_idx_t rd;
        word_t    data;
    } mem_wb_t;

endpackage

`default_nettype wire

//--- source/pipe_reg.sv
/*
 * Stage register for any packed payload. Holds while i_en is low and
 * loads an all-zero, invalid payload when i_bubble is set.
 */
`default_nettype none

module pipe_reg import cpu_pkg::*; #(
    parameter type payload_t = word_t   // Stage payload struct
) (
    input  wire logic     clk,
    input  wire logic     i_reset,
    input  wire logic     i_en,        // Load, else hold
    input  wire logic     i_bubble,    // Load zero instead of i_d
    input  wire payload_t i_d,
    output payload_t      o_q
);

    always_ff @(posedge clk) begin
        if (i_reset) begin
            o_q <= '0;                          // Empty stage, valid low
        end else if (i_en) begin
            o_q <= i_bubble ? payload_t'('0) : i_d;
        end
    end

endmodule

`default_nettype wire

//--- source/unified_mem.sv
/*
 * Single-port program and data memory, word addressed.
 * Read is combinational from i_addr, write lands on the clock edge.
 */
`default_nettype none

`include "cpu_consts.svh"

module unified_mem import cpu_pkg::*; (
    input  wire logic                   clk,
    input  wire logic                   i_we,
    input  wire logic [`CPU_MEM_AW-1:0] i_addr,    // Word index
    input  wire word_t                  i_wdata,
    output word_t                       o_rdata
);

    word_t mem [`CPU_MEM_WORDS];    // Program and data share the array

    always_ff @(posedge clk) begin
        if (i_we) begin
            mem[i_addr] <= i_wdata;
        end
    end

    // Same index for read and write, one port
    assign o_rdata = mem[i_addr];

endmodule

`default_nettype wire

//--- source/mem_arbiter.sv
/*
 * Fixed-priority access to the unified memory port.
 * Load port first, then the memory stage, then instruction fetch.
 */
`default_nettype none

`include "cpu_consts.svh"

module mem_arbiter import cpu_pkg::*; (
    input  wire logic                  i_load_we,     // Preload, only while in reset
    input  wire word_t                 i_load_addr,   // Byte address
    input  wire word_t                 i_load_data,
    input  wire logic                  i_data_req,    // Load or store from memory stage
    input  wire logic                  i_data_we,
    input  wire word_t                 i_data_addr,
    input  wire word_t                 i_data_wdata,
    input  wire word_t                 i_fetch_addr,  // PC
    output logic                       o_fetch_grant,
    output word_t                      o_rdata,       // Shared by both requesters
    output logic                       o_mem_we,
    output logic [`CPU_MEM_AW-1:0]     o_mem_addr,
    output word_t                      o_mem_wdata,
    input  wire word_t                 i_mem_rdata
);

    always_comb begin
        o_mem_we    = 1'b0;
        o_mem_addr  = i_fetch_addr[`CPU_MEM_AW+1:2];   // Fetch when idle
        o_mem_wdata = i_data_wdata;
        if (i_load_we) begin
            o_mem_we    = 1'b1;
            o_mem_addr  = i_load_addr[`CPU_MEM_AW+1:2];
            o_mem_wdata = i_load_data;
        end else if (i_data_req) begin
            o_mem_we    = i_data_we;
            o_mem_addr  = i_data_addr[`CPU_MEM_AW+1:2];
        end
    end

    assign o_fetch_grant = !i_load_we && !i_data_req;   // Fetch loses any contention
    assign o_rdata       = i_mem_rdata;

endmodule

`default_nettype wire

//--- source/fetch_unit.sv
/*
 * Program counter and instruction request. The PC moves on only when
 * the fetch is granted and decode does not interlock.
 */
`default_nettype none

module fetch_unit import cpu_pkg::*; (
    input  wire logic  clk,
    input  wire logic  i_reset,
    input  wire logic  i_grant,        // Memory port free this cycle
    input  wire logic  i_stall,        // Decode interlock
    input  wire word_t i_rdata,        // Instruction word
    output word_t      o_fetch_addr,
    output if_id_t     o_if_id,
    output logic       o_if_en         // IF/ID load enable
);

    word_t pc;
    logic  advance;

    assign advance = i_grant && !i_stall;

    always_ff @(posedge clk) begin
        if (i_reset) begin
            pc <= '0;
        end else if (advance) begin
            pc <= pc + word_t'(4);
        end
    end

    assign o_fetch_addr = pc;

    // Denied fetch becomes a bubble in IF/ID
    always_comb begin
        o_if_id = '0;
        if (i_grant) begin
            o_if_id.valid = 1'b1;
            o_if_id.pc    = pc;
            o_if_id.instr = i_rdata;
        end
    end

    assign o_if_en = !i_stall;          // Interlock holds IF/ID over denial

endmodule

`default_nettype wire

//--- decode/reg_file.sv
/*
 * 32-entry register file, two read ports and one write port.
 * A write is visible to the reads of the same cycle; x0 reads zero.
 */
`default_nettype none

`include "cpu_consts.svh"

module reg_file import cpu_pkg::*; (
    input  wire logic     clk,
    input  wire logic     i_reset,
    input  wire reg_idx_t i_rs1,
    input  wire reg_idx_t i_rs2,
    output word_t         o_rs1_data,
    output word_t         o_rs2_data,
    input  wire logic     i_we,         // From write-back
    input  wire reg_idx_t i_rd,
    input  wire word_t    i_wdata
);

    word_t regs [1:`CPU_NUM_REGS-1];    // No storage for x0

    always_ff @(posedge clk) begin
        if (i_reset) begin
            for (int i = 1; i < `CPU_NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (i_we && i_rd != '0) begin
            regs[i_rd] <= i_wdata;
        end
    end

    function automatic word_t read_port(reg_idx_t idx);
        if (idx == '0) begin
            return '0;
        end
        if (i_we && i_rd == idx) begin
            return i_wdata;             // Write-first bypass
        end
        return regs[idx];
    endfunction

    always_comb begin
        o_rs1_data = read_port(i_rs1);
        o_rs2_data = read_port(i_rs2);
    end

endmodule

`default_nettype wire

//--- decode/instr_decode.sv
/*
 * Decode of ADD, SUB, AND, OR, XOR, ADDI, LW and SW with immediate
 * generation. Any other word decodes as a bubble. Interlocks on a
 * source register still pending in execute or memory.
 */
`default_nettype none

module instr_decode import cpu_pkg::*; (
    input  wire if_id_t   i_if_id,
    input  wire id_ex_t   i_id_ex_q,     // Instruction now in execute
    input  wire ex_mem_t  i_ex_mem_q,    // Instruction now in memory
    output reg_idx_t      o_rs1,
    output reg_idx_t      o_rs2,
    input  wire word_t    i_rs1_data,
    input  wire word_t    i_rs2_data,
    output id_ex_t        o_id_ex,
    output logic          o_stall
);

    localparam logic [6:0] OPC_REG   = 7'b0110011;
    localparam logic [6:0] OPC_IMM   = 7'b0010011;
    localparam logic [6:0] OPC_LOAD  = 7'b0000011;
    localparam logic [6:0] OPC_STORE = 7'b0100011;

    word_t      instr;
    logic [6:0] opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;
    ctrl_t      ctrl;
    word_t      imm;
    logic       legal;      // Supported encoding
    logic       dec_valid;
    logic       uses_rs2;   // R-type and SW read rs2
    logic       raw_rs1;
    logic       raw_rs2;

    assign instr  = i_if_id.instr;
    assign opcode = instr[6:0];
    assign funct3 = instr[14:12];
    assign funct7 = instr[31:25];
    assign o_rs1  = instr[19:15];
    assign o_rs2  = instr[24:20];

    always_comb begin
        ctrl  = '0;
        imm   = '0;
        legal = 1'b0;
        case (opcode)
            OPC_REG: begin
                legal          = 1'b1;
                ctrl.reg_write = 1'b1;
                case ({funct7, funct3})
                    {7'b0000000, 3'b000}: ctrl.op = OP_ADD;
                    {7'b0100000, 3'b000}: ctrl.op = OP_SUB;
                    {7'b0000000, 3'b111}: ctrl.op = OP_AND;
                    {7'b0000000, 3'b110}: ctrl.op = OP_OR;
                    {7'b0000000, 3'b100}: ctrl.op = OP_XOR;
                    default:              legal   = 1'b0;
                endcase
            end
            OPC_IMM: begin                                  // ADDI only
                legal          = (funct3 == 3'b000);
                ctrl.op        = OP_ADD;
                ctrl.use_imm   = 1'b1;
                ctrl.reg_write = 1'b1;
                imm            = {{20{instr[31]}}, instr[31:20]};
            end
            OPC_LOAD: begin                                 // LW only
                legal          = (funct3 == 3'b010);
                ctrl.op        = OP_LOAD;
                ctrl.use_imm   = 1'b1;
                ctrl.reg_write = 1'b1;
                ctrl.mem_read  = 1'b1;
                imm            = {{20{instr[31]}}, instr[31:20]};
            end
            OPC_STORE: begin                                // SW only
                legal          = (funct3 == 3'b010);
                ctrl.op        = OP_STORE;
                ctrl.use_imm   = 1'b1;
                ctrl.mem_write = 1'b1;
                imm            = {{20{instr[31]}}, instr[31:25], instr[11:7]};
            end
            default: ;                                      // Bubble, zero word included
        endcase
    end

    assign dec_valid = i_if_id.valid && legal;
    assign uses_rs2  = !ctrl.use_imm || ctrl.mem_write;

    // Pending write to a nonzero rd in execute or memory
    assign raw_rs1 = (o_rs1 != '0) &&
        ((i_id_ex_q.valid && i_id_ex_q.ctrl.reg_write && i_id_ex_q.rd == o_rs1) ||
         (i_ex_mem_q.valid && i_ex_mem_q.ctrl.reg_write && i_ex_mem_q.rd == o_rs1));
    assign raw_rs2 = (o_rs2 != '0) &&
        ((i_id_ex_q.valid && i_id_ex_q.ctrl.reg_write && i_id_ex_q.rd == o_rs2) ||
         (i_ex_mem_q.valid && i_ex_mem_q.ctrl.reg_write && i_ex_mem_q.rd == o_rs2));

    assign o_stall = dec_valid && (raw_rs1 || (uses_rs2 && raw_rs2));

    always_comb begin
        o_id_ex = '0;
        if (dec_valid) begin
            o_id_ex.valid    = 1'b1;
            o_id_ex.ctrl     = ctrl;
            o_id_ex.pc       = i_if_id.pc;
            o_id_ex.rs1_data = i_rs1_data;
            o_id_ex.rs2_data = i_rs2_data;
            o_id_ex.imm      = imm;
            o_id_ex.rd       = ctrl.reg_write ? instr[11:7] : '0;   // SW has no rd
        end
    end

endmodule

`default_nettype wire

//--- source/execute_unit.sv
/*
 * Execute stage: ALU for the register and immediate operations and
 * effective address for loads and stores. rs2 goes on as store data.
 */
`default_nettype none

module execute_unit import cpu_pkg::*; (
    input  wire id_ex_t i_id_ex,
    output ex_mem_t     o_ex_mem
);

    word_t op_a;
    word_t op_b;

    assign op_a = i_id_ex.rs1_data;
    assign op_b = i_id_ex.ctrl.use_imm ? i_id_ex.imm : i_id_ex.rs2_data;

    always_comb begin
        o_ex_mem.valid      = i_id_ex.valid;
        o_ex_mem.ctrl       = i_id_ex.ctrl;
        o_ex_mem.rd         = i_id_ex.rd;
        o_ex_mem.store_data = i_id_ex.rs2_data;     // SW value
        case (i_id_ex.ctrl.op)
            OP_SUB:  o_ex_mem.result = op_a - op_b;
            OP_AND:  o_ex_mem.result = op_a & op_b;
            OP_OR:   o_ex_mem.result = op_a | op_b;
            OP_XOR:  o_ex_mem.result = op_a ^ op_b;
            default: o_ex_mem.result = op_a + op_b; // ADD, ADDI, LW and SW address
        endcase
    end

endmodule

`default_nettype wire

//--- source/mem_access.sv
/*
 * Memory stage. Requests the shared port for valid loads and stores,
 * reports stores on the store strobe and forms the write-back payload.
 */
`default_nettype none

module mem_access import cpu_pkg::*; (
    input  wire ex_mem_t i_ex_mem,
    output logic         o_data_req,
    output logic         o_data_we,
    output word_t        o_data_addr,
    output word_t        o_data_wdata,
    input  wire word_t   i_rdata,        // Loaded word, same cycle
    output mem_wb_t      o_mem_wb,
    output logic         o_store_valid,
    output word_t        o_store_addr,
    output word_t        o_store_data
);

    logic is_load;
    logic is_store;

    assign is_load  = i_ex_mem.valid && i_ex_mem.ctrl.mem_read;
    assign is_store = i_ex_mem.valid && i_ex_mem.ctrl.mem_write;

    assign o_data_req   = is_load || is_store;     // Takes the port from fetch
    assign o_data_we    = is_store;
    assign o_data_addr  = i_ex_mem.result;
    assign o_data_wdata = i_ex_mem.store_data;

    assign o_store_valid = is_store;
    assign o_store_addr  = i_ex_mem.result;
    assign o_store_data  = i_ex_mem.store_data;

    always_comb begin
        o_mem_wb.valid     = i_ex_mem.valid;
        o_mem_wb.reg_write = i_ex_mem.valid && i_ex_mem.ctrl.reg_write;
        o_mem_wb.rd        = i_ex_mem.rd;
        o_mem_wb.data      = is_load ? i_rdata : i_ex_mem.result;
    end

endmodule

`default_nettype wire

//--- source/cpu_core.sv
/*
 * Top of the five-stage core. Connects fetch, decode, execute and
 * memory through four stage registers around one arbitrated memory.
 * Results leave on the retire and store strobes.
 */
`default_nettype none

`include "cpu_consts.svh"

module cpu_core import cpu_pkg::*; (
    input  wire logic  clk,
    input  wire logic  i_reset,
    input  wire logic  i_load_we,        // Preload while in reset
    input  wire word_t i_load_addr,      // Byte address
    input  wire word_t i_load_data,
    output logic       o_retire_valid,
    output reg_idx_t   o_retire_rd,
    output word_t      o_retire_data,
    output logic       o_store_valid,
    output word_t      o_store_addr,
    output word_t      o_store_data
);

    if_id_t  if_id_d,  if_id_q;
    id_ex_t  id_ex_d,  id_ex_q;
    ex_mem_t ex_mem_d, ex_mem_q;
    mem_wb_t mem_wb_d, mem_wb_q;

    word_t    fetch_addr;
    logic     fetch_grant;
    logic     if_en;
    logic     stall;            // Decode interlock
    word_t    arb_rdata;
    reg_idx_t rs1, rs2;
    word_t    rs1_data, rs2_data;
    logic     data_req, data_we;
    word_t    data_addr, data_wdata;
    logic     mem_we;
    logic [`CPU_MEM_AW-1:0] mem_addr;
    word_t    mem_wdata, mem_rdata;
    logic     wb_we;

    fetch_unit u_fetch_unit (
        .clk(clk), .i_reset(i_reset), .i_grant(fetch_grant), .i_stall(stall),
        .i_rdata(arb_rdata), .o_fetch_addr(fetch_addr), .o_if_id(if_id_d), .o_if_en(if_en)
    );

    pipe_reg #(.payload_t(if_id_t)) u_if_id (
        .clk(clk), .i_reset(i_reset), .i_en(if_en), .i_bubble(1'b0),
        .i_d(if_id_d), .o_q(if_id_q)
    );

    instr_decode u_instr_decode (
        .i_if_id(if_id_q), .i_id_ex_q(id_ex_q), .i_ex_mem_q(ex_mem_q),
        .o_rs1(rs1), .o_rs2(rs2), .i_rs1_data(rs1_data), .i_rs2_data(rs2_data),
        .o_id_ex(id_ex_d), .o_stall(stall)
    );

    reg_file u_reg_file (
        .clk(clk), .i_reset(i_reset), .i_rs1(rs1), .i_rs2(rs2),
        .o_rs1_data(rs1_data), .o_rs2_data(rs2_data),
        .i_we(wb_we), .i_rd(mem_wb_q.rd), .i_wdata(mem_wb_q.data)
    );

    // Interlocked instruction stays in IF/ID, execute gets a bubble
    pipe_reg #(.payload_t(id_ex_t)) u_id_ex (
        .clk(clk), .i_reset(i_reset), .i_en(1'b1), .i_bubble(stall),
        .i_d(id_ex_d), .o_q(id_ex_q)
    );

    execute_unit u_execute_unit (.i_id_ex(id_ex_q), .o_ex_mem(ex_mem_d));

    pipe_reg #(.payload_t(ex_mem_t)) u_ex_mem (
        .clk(clk), .i_reset(i_reset), .i_en(1'b1), .i_bubble(1'b0),
        .i_d(ex_mem_d), .o_q(ex_mem_q)
    );

    mem_access u_mem_access (
        .i_ex_mem(ex_mem_q), .o_data_req(data_req), .o_data_we(data_we),
        .o_data_addr(data_addr), .o_data_wdata(data_wdata), .i_rdata(arb_rdata),
        .o_mem_wb(mem_wb_d), .o_store_valid(o_store_valid),
        .o_store_addr(o_store_addr), .o_store_data(o_store_data)
    );

    pipe_reg #(.payload_t(mem_wb_t)) u_mem_wb (
        .clk(clk), .i_reset(i_reset), .i_en(1'b1), .i_bubble(1'b0),
        .i_d(mem_wb_d), .o_q(mem_wb_q)
    );

    mem_arbiter u_mem_arbiter (
        .i_load_we(i_load_we), .i_load_addr(i_load_addr), .i_load_data(i_load_data),
        .i_data_req(data_req), .i_data_we(data_we), .i_data_addr(data_addr),
        .i_data_wdata(data_wdata), .i_fetch_addr(fetch_addr),
        .o_fetch_grant(fetch_grant), .o_rdata(arb_rdata),
        .o_mem_we(mem_we), .o_mem_addr(mem_addr), .o_mem_wdata(mem_wdata),
        .i_mem_rdata(mem_rdata)
    );

    unified_mem u_unified_mem (
        .clk(clk), .i_we(mem_we), .i_addr(mem_addr),
        .i_wdata(mem_wdata), .o_rdata(mem_rdata)
    );

    // Write-back and retire strobe
    assign wb_we          = mem_wb_q.valid && mem_wb_q.reg_write;
    assign o_retire_valid = wb_we;
    assign o_retire_rd    = mem_wb_q.rd;
    assign o_retire_data  = mem_wb_q.data;

endmodule

`default_nettype wire

//--- tb/cpu_core_tb.sv
/*
 * Testbench of the pipelined core. Builds a random 48-instruction program
 * and a random data region, preloads memory while in reset and checks each
 * retire and store strobe in order against an in-order ISA model.
 */
`default_nettype none

`include "cpu_consts.svh"

module cpu_core_tb;

    localparam int NUM_INSTR      = 48;
    localparam int MEM_WORDS      = `CPU_MEM_WORDS;
    localparam int DATA_BASE      = 128;                    // Word index of byte 512
    localparam int RESET_CYCLES   = MEM_WORDS + 17;         // Preload plus 16 idle cycles
    localparam int TIMEOUT_CYCLES = NUM_INSTR * 12 + RESET_CYCLES;
    localparam int QUIET_CYCLES   = 32;                     // Watch for stray strobes

    // Instruction kinds of the generator
    localparam logic [2:0] KIND_ADD  = 3'd0;
    localparam logic [2:0] KIND_SUB  = 3'd1;
    localparam logic [2:0] KIND_AND  = 3'd2;
    localparam logic [2:0] KIND_OR   = 3'd3;
    localparam logic [2:0] KIND_XOR  = 3'd4;
    localparam logic [2:0] KIND_ADDI = 3'd5;
    localparam logic [2:0] KIND_LW   = 3'd6;
    localparam logic [2:0] KIND_SW   = 3'd7;

    // RV32I major opcodes
    localparam logic [6:0] OPC_REG   = 7'b0110011;
    localparam logic [6:0] OPC_IMM   = 7'b0010011;
    localparam logic [6:0] OPC_LOAD  = 7'b0000011;
    localparam logic [6:0] OPC_STORE = 7'b0100011;

    logic        clk;
    logic        reset;
    logic        load_we;
    logic [31:0] load_addr;
    logic [31:0] load_data;
    logic        retire_valid;
    logic [4:0]  retire_rd;
    logic [31:0] retire_data;
    logic        store_valid;
    logic [31:0] store_addr;
    logic [31:0] store_data;

    logic [31:0] lfsr_state;
    logic [2:0]  prog_kind [NUM_INSTR];
    logic [4:0]  prog_rd   [NUM_INSTR];
    logic [4:0]  prog_rs1  [NUM_INSTR];
    logic [4:0]  prog_rs2  [NUM_INSTR];
    logic [11:0] prog_imm  [NUM_INSTR];
    logic [31:0] image     [MEM_WORDS];     // Preload contents
    logic [31:0] ref_mem   [MEM_WORDS];     // Model memory
    logic [31:0] exp_ret_rd [$];
    logic [31:0] exp_ret_data [$];
    logic [31:0] exp_st_addr [$];
    logic [31:0] exp_st_data [$];
    int          n_ret;
    int          n_st;
    int          ret_seen;                  // Retire strobes matched so far
    int          st_seen;
    int          cycle_count;

    cpu_core u_cpu_core (
        .clk(clk), .i_reset(reset),
        .i_load_we(load_we), .i_load_addr(load_addr), .i_load_data(load_data),
        .o_retire_valid(retire_valid), .o_retire_rd(retire_rd), .o_retire_data(retire_data),
        .o_store_valid(store_valid), .o_store_addr(store_addr), .o_store_data(store_data)
    );

    always #20 clk = ~clk;                  // Period 40

    // Fibonacci LFSR with taps x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    function automatic logic [31:0] take_bits(input int n);
        logic [31:0] value;
        value = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_step(lfsr_state);
            value      = {value[30:0], lfsr_state[0]};  // One step per bit
        end
        return value;
    endfunction

    function automatic void build_program();
        logic [31:0] bits;
        for (int i = 0; i < NUM_INSTR; i++) begin
            bits         = take_bits(24);
            prog_kind[i] = bits[23:21];
            prog_rd[i]   = {2'b00, bits[20:18]};         // x0..x7 only
            prog_rs1[i]  = {2'b00, bits[17:15]};
            prog_rs2[i]  = {2'b00, bits[14:12]};
            prog_imm[i]  = bits[11:0];
            if (prog_kind[i] == KIND_LW || prog_kind[i] == KIND_SW) begin
                prog_rs1[i] = 5'd0;                        // Base x0
                prog_imm[i] = {3'b001, bits[6:0], 2'b00};  // 512 + 4k up to 1020
            end
        end
    endfunction

    function automatic logic [31:0] encode_instr(input int i);
        case (prog_kind[i])
            KIND_ADD:  return {7'b0000000, prog_rs2[i], prog_rs1[i], 3'b000, prog_rd[i], OPC_REG};
            KIND_SUB:  return {7'b0100000, prog_rs2[i], prog_rs1[i], 3'b000, prog_rd[i], OPC_REG};
            KIND_AND:  return {7'b0000000, prog_rs2[i], prog_rs1[i], 3'b111, prog_rd[i], OPC_REG};
            KIND_OR:   return {7'b0000000, prog_rs2[i], prog_rs1[i], 3'b110, prog_rd[i], OPC_REG};
            KIND_XOR:  return {7'b0000000, prog_rs2[i], prog_rs1[i], 3'b100, prog_rd[i], OPC_REG};
            KIND_ADDI: return {prog_imm[i], prog_rs1[i], 3'b000, prog_rd[i], OPC_IMM};
            KIND_LW:   return {prog_imm[i], prog_rs1[i], 3'b010, prog_rd[i], OPC_LOAD};
            default:   return {prog_imm[i][11:5], prog_rs2[i], prog_rs1[i], 3'b010,
                               prog_imm[i][4:0], OPC_STORE};       // SW
        endcase
    endfunction

    // Program then zero words up to byte 512 and random data above
    function automatic void build_image();
        for (int w = 0; w < MEM_WORDS; w++) begin
            if (w < NUM_INSTR) begin
                image[w] = encode_instr(w);
            end else if (w < DATA_BASE) begin
                image[w] = '0;                      // Illegal word that runs as a bubble
            end else begin
                image[w] = take_bits(32);
            end
        end
    endfunction

    // In-order ISA model of the whole program
    function automatic void run_reference();
        logic [31:0] regs [8];
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] imm;
        logic [31:0] addr;
        logic [31:0] result;
        for (int r = 0; r < 8; r++) begin
            regs[r] = '0;
        end
        for (int w = 0; w < MEM_WORDS; w++) begin
            ref_mem[w] = image[w];
        end
        for (int i = 0; i < NUM_INSTR; i++) begin
            a      = regs[prog_rs1[i][2:0]];
            b      = regs[prog_rs2[i][2:0]];
            imm    = {{20{prog_imm[i][11]}}, prog_imm[i]};
            addr   = a + imm;
            result = '0;
            case (prog_kind[i])
                KIND_ADD:  result = a + b;
                KIND_SUB:  result = a - b;
                KIND_AND:  result = a & b;
                KIND_OR:   result = a | b;
                KIND_XOR:  result = a ^ b;
                KIND_ADDI: result = a + imm;
                KIND_LW:   result = ref_mem[addr[9:2]];
                default: begin                      // SW
                    ref_mem[addr[9:2]] = b;
                    exp_st_addr.push_back(addr);
                    exp_st_data.push_back(b);
                end
            endcase
            if (prog_kind[i] != KIND_SW) begin
                exp_ret_rd.push_back({27'b0, prog_rd[i]});
                exp_ret_data.push_back(result);    // x0 write still retires its value
                if (prog_rd[i] != 5'd0) begin
                    regs[prog_rd[i][2:0]] = result;
                end
            end
        end
        n_ret = exp_ret_rd.size();
        n_st  = exp_st_addr.size();
    endfunction

    task automatic abort_run(input string reason);
        $display("%s", reason);
        $display("Simulation finished: FAIL");
        $fatal(1, "Run stopped at the first failure");
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] expected);
        if (got !== expected) begin
            abort_run($sformatf("Error at time %0t: %s is %h, expected %h",
                                $time, name, got, expected));
        end
    endtask

    // One word per cycle through the load port
    task automatic preload_memory();
        for (int w = 0; w < MEM_WORDS; w++) begin
            @(posedge clk);
            load_we   <= 1'b1;
            load_addr <= w * 4;
            load_data <= image[w];
        end
        @(posedge clk);
        load_we <= 1'b0;
    endtask

    // Strobes sampled mid-cycle
    always @(negedge clk) begin
        if (!reset && retire_valid) begin
            if (ret_seen >= n_ret) begin
                abort_run($sformatf("Unexpected retire strobe at time %0t after all %0d retires",
                                    $time, n_ret));
            end else begin
                check_value("o_retire_rd", {27'b0, retire_rd}, exp_ret_rd[ret_seen]);
                check_value("o_retire_data", retire_data, exp_ret_data[ret_seen]);
                ret_seen = ret_seen + 1;
            end
        end
        if (!reset && store_valid) begin
            if (st_seen >= n_st) begin
                abort_run($sformatf("Unexpected store strobe at time %0t after all %0d stores",
                                    $time, n_st));
            end else begin
                check_value("o_store_addr", store_addr, exp_st_addr[st_seen]);
                check_value("o_store_data", store_data, exp_st_data[st_seen]);
                st_seen = st_seen + 1;
            end
        end
    end

    always @(posedge clk) begin
        cycle_count = cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            abort_run($sformatf("Timeout: the pipeline did not finish the program in %0d cycles",
                                TIMEOUT_CYCLES));
        end
    end

    initial begin
        clk         = 1'b0;
        reset       = 1'b1;
        load_we     = 1'b0;
        load_addr   = '0;
        load_data   = '0;
        ret_seen    = 0;
        st_seen     = 0;
        cycle_count = 0;
        lfsr_state  = 32'h6a1e;                     // Fixed seed
        build_program();
        build_image();
        run_reference();
        preload_memory();
        repeat (16) @(posedge clk);                 // Reset tail after the preload
        reset <= 1'b0;
        while (!(ret_seen == n_ret && st_seen == n_st)) begin
            @(posedge clk);
        end
        repeat (QUIET_CYCLES) @(posedge clk);       // Zero words must stay silent
        $display("Simulation finished: PASS");
        $finish;
    end

endmodule

`default_nettype wire

//--- cpu_core.f
+incdir+common
common/cpu_pkg.sv
source/pipe_reg.sv
source/unified_mem.sv
source/mem_arbiter.sv
source/fetch_unit.sv
decode/reg_file.sv
decode/instr_decode.sv
source/execute_unit.sv
source/mem_access.sv
source/cpu_core.sv
tb/cpu_core_tb.sv
